/* filelist.f */
+incdir+rtl
rtl/dadda_pkg.sv
rtl/dadda_ctrl.sv
rtl/partial_product_gen.sv
rtl/dadda_step.sv
rtl/final_adder.sv
rtl/dadda_mult_top.sv
bench/dadda_mult_tb.sv

/* bench/dadda_mult_tb.sv */
`default_nettype none

`include "dadda_params.svh"

module dadda_mult_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W   = `DADDA_WIDTH;
    localparam int P   = `DADDA_PROD_WIDTH;
    localparam int LAT = `DADDA_LATENCY;
    localparam int TIMEOUT = 20;

    logic         clk;
    logic         nrst;
    logic         start;
    logic [W-1:0] a;
    logic [W-1:0] b;
    wire  [P-1:0] product;
    wire          busy;
    wire          done;

    integer seed;
    int     error_count;

    // expected products and the cycle they were accepted in
    logic [P-1:0] exp_q [$];
    int           acc_q [$];
    int           cyc;
    int           busy_cnt;
    int           accepted_at;
    logic [P-1:0] expected;
    bit           prev_done;

    dadda_mult_top dadda_mult_top_inst (
        .clk     (clk),
        .nrst    (nrst),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .busy    (busy),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // plain unsigned product, both operands widened first
    function automatic logic [P-1:0] ref_product(input logic [W-1:0] x, input logic [W-1:0] y);
        logic [P-1:0] wide_x;
        logic [P-1:0] wide_y;
        wide_x = {{(P - W){1'b0}}, x};
        wide_y = {{(P - W){1'b0}}, y};
        return wide_x * wide_y;
    endfunction

    task automatic note_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [P-1:0] exp_val,
                               input logic [P-1:0] act_val);
        assert (act_val === exp_val) else begin
            error_count++;
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy) begin
            note_error("busy never dropped within the timeout");
        end
    endtask

    task automatic wait_done();
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            note_error("done never came within the timeout");
        end
    endtask

    // one operation, start dropped right after it is taken
    task automatic run_op(input logic [W-1:0] x, input logic [W-1:0] y);
        wait_idle();
        @(posedge clk);
        #1;
        a = x;
        b = y;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (busy) else note_error("start was not accepted while idle");
        // operands are junk from here on
        a = $random(seed);
        b = $random(seed);
        wait_done();
    endtask

    // start held high, junk operands while busy
    task automatic run_burst(input int count);
        int k;
        int n;
        bit seen;
        wait_idle();
        @(posedge clk);
        #1;
        a = $random(seed);
        b = $random(seed);
        start = 1'b1;
        for (k = 0; k < count; k++) begin
            n = 0;
            seen = 1'b0;
            @(posedge clk);
            #1;
            assert (busy) else note_error("held start was not accepted");
            while (!seen && n < TIMEOUT) begin
                @(posedge clk);
                #1;
                seen = done;
                n++;
                if (seen && k < count - 1) begin
                    // operands for the edge right after done
                    a = $random(seed);
                    b = $random(seed);
                end else if (seen) begin
                    start = 1'b0;
                end else begin
                    a = $random(seed);
                    b = $random(seed);
                end
            end
            if (!seen) begin
                note_error("done never came during the burst");
                start = 1'b0;
            end
        end
    endtask

    task automatic check_hold(input int cycles);
        logic [P-1:0] held;
        int i;
        wait_idle();
        held = product;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            a = $random(seed);
            b = $random(seed);
            @(negedge clk);
            check_value("product", held, product);
            check_value("busy", '0, busy);
        end
    endtask

    // compare process, sampled at the falling edge
    always @(negedge clk) begin
        if (nrst) begin
            cyc = cyc + 1;
            assert (!(done && prev_done))
                else note_error("done stayed high for more than one cycle");
            assert (!(done && busy))
                else note_error("done and busy were high together");
            if (done) begin
                if (exp_q.size() == 0) begin
                    note_error("done pulse without an accepted start");
                end else begin
                    expected = exp_q.pop_front();
                    accepted_at = acc_q.pop_front();
                    check_value("product", expected, product);
                    // acceptance is seen one cycle before its edge
                    check_value("done latency", LAT + 1, cyc - accepted_at);
                    check_value("busy cycles", LAT, busy_cnt);
                end
            end
            if (start && !busy) begin
                exp_q.push_back(ref_product(a, b));
                acc_q.push_back(cyc);
                busy_cnt = 0;
            end
            if (busy) begin
                busy_cnt++;
            end
            prev_done = done;
        end
    end

    initial begin
        int i;
        seed = 32'h16f922e2;
        error_count = 0;
        cyc = 0;
        busy_cnt = 0;
        prev_done = 1'b0;
        nrst = 1'b0;
        start = 1'b0;
        a = '0;
        b = '0;

        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(negedge clk);
        check_value("busy", '0, busy);
        check_value("done", '0, done);
        check_value("product", '0, product);

        // directed corners
        run_op('0, '0);
        run_op('0, '1);
        run_op('1, '0);
        run_op('1, '1);
        run_op(24'd1, 24'h5a3c91);
        run_op(24'h5a3c91, 24'd1);
        run_op('1, 24'd1);
        for (i = 0; i < W; i++) begin
            run_op(24'd1 << i, 24'd1 << (W - 1 - i));
        end
        run_op(24'd1 << (W - 1), 24'd1 << (W - 1));

        check_hold(10);

        for (i = 0; i < 200; i++) begin
            run_op($random(seed), $random(seed));
        end

        run_burst(6);
        check_hold(10);

        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            note_error("accepted operations never completed");
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/dadda_mult_top.sv */
`default_nettype none

`include "dadda_params.svh"

module dadda_mult_top import dadda_pkg::*; (
    input  wire           clk,
    input  wire           nrst,
    input  wire           start,
    input  wire operand_t a,
    input  wire operand_t b,
    output wire product_t product,
    output wire           busy,
    output wire           done
);

    wire load;
    wire capture;

    // stage[0] is the raw matrix, stage[k+1] the output of step k
    wire dot_matrix_t stage [0:`DADDA_STEPS];

    dadda_ctrl dadda_ctrl_inst (
        .clk     (clk),
        .nrst    (nrst),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .load    (load),
        .capture (capture)
    );

    partial_product_gen partial_product_gen_inst (
        .clk  (clk),
        .nrst (nrst),
        .load (load),
        .a    (a),
        .b    (b),
        .dots (stage[0])
    );

    for (genvar k = 0; k < `DADDA_STEPS; k++) begin : g_step
        dadda_step #(
            .STEP (k)
        ) dadda_step_inst (
            .clk      (clk),
            .nrst     (nrst),
            .dots_in  (stage[k]),
            .dots_out (stage[k + 1])
        );
    end

    final_adder final_adder_inst (
        .clk     (clk),
        .nrst    (nrst),
        .capture (capture),
        .dots    (stage[`DADDA_STEPS]),
        .product (product)
    );

endmodule

`default_nettype wire

/* rtl/final_adder.sv */
`default_nettype none

module final_adder import dadda_pkg::*; (
    input  wire              clk,
    input  wire              nrst,
    input  wire              capture,
    input  wire dot_matrix_t dots,
    output product_t         product
);

    localparam int P = $bits(product_t);

    product_t   row0;
    product_t   row1;
    logic [P:0] sum;

    // two rows left after the last step
    always_comb begin
        for (int c = 0; c < P; c++) begin
            row0[c] = dots[c][0];
            row1[c] = dots[c][1];
        end
        sum = {1'b0, row0} + {1'b0, row1};
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            product <= '0;
        end else if (capture) begin
            product <= sum[P-1:0];
        end
    end

    // a 24x24 product fits in 48 bits, any carry means the tree is wrong
    assert property (@(posedge clk) disable iff (!nrst) capture |-> !sum[P])
        else $error("final_adder: carry out of the top bit");

endmodule

`default_nettype wire

/* rtl/dadda_step.sv */
`default_nettype none

module dadda_step import dadda_pkg::*; #(
    parameter int STEP = 0
) (
    input  wire              clk,
    input  wire              nrst,
    input  wire dot_matrix_t dots_in,
    output dot_matrix_t      dots_out
);

    localparam int W   = $bits(operand_t);
    localparam int P   = $bits(product_t);
    localparam int TGT = dadda_target(STEP);

    // carries leaving column col-1 in this step
    function automatic int carries_into(int col);
        int cin;
        int exc;
        cin = 0;
        for (int c = 0; c < col; c++) begin
            exc = height_after(c, STEP - 1) + cin - TGT;
            cin = (exc > 0) ? (exc + 1) / 2 : 0;
        end
        return cin;
    endfunction

    function automatic dot_matrix_t valid_mask(int k);
        dot_matrix_t m;
        int h;
        m = '0;
        for (int c = 0; c < P; c++) begin
            h = height_after(c, k);
            for (int r = 0; r < W; r++) begin
                m[c][r] = (r < h);
            end
        end
        return m;
    endfunction

    localparam dot_matrix_t IN_MASK = valid_mask(STEP - 1);

    // carry[c][n] is the n-th carry leaving column c
    wire [P-1:0][W-1:0] carry;
    wire dot_matrix_t   reduced;

    if (carries_into(P) != 0) begin : g_top_overflow
        $error("dadda_step %0d: carry leaves the top column", STEP);
    end

    for (genvar c = 0; c < P; c++) begin : g_col
        localparam int HIN   = height_after(c, STEP - 1);
        localparam int CIN   = carries_into(c);
        localparam int AVAIL = HIN + CIN;
        localparam int EXC   = AVAIL - TGT;
        localparam int NFA   = (EXC > 0) ? EXC / 2 : 0;
        localparam int NHA   = (EXC > 0) ? EXC % 2 : 0;
        localparam int NA    = NFA + NHA;
        localparam int FIRST = 3 * NFA + 2 * NHA;
        localparam int NODES = AVAIL + NA;

        if (AVAIL == 0) begin : g_empty
            assign reduced[c] = '0;
            assign carry[c]   = '0;
        end else begin : g_reduce
            // queue of dots, then incoming carries, then sums of this column
            wire [NODES-1:0] node;

            for (genvar i = 0; i < HIN; i++) begin : g_dot
                assign node[i] = dots_in[c][i];
            end
            for (genvar i = 0; i < CIN; i++) begin : g_cin
                assign node[HIN + i] = carry[c - 1][i];
            end

            // each adder eats from the head, its sum joins the tail
            for (genvar f = 0; f < NFA; f++) begin : g_fa
                assign node[AVAIL + f] = node[3*f] ^ node[3*f + 1] ^ node[3*f + 2];
                assign carry[c][f]     = (node[3*f] & node[3*f + 1]) |
                                         (node[3*f + 2] & (node[3*f] ^ node[3*f + 1]));
            end

            // odd excess, one half adder brings the column to target
            if (NHA == 1) begin : g_ha
                assign node[AVAIL + NFA] = node[3*NFA] ^ node[3*NFA + 1];
                assign carry[c][NFA]     = node[3*NFA] & node[3*NFA + 1];
            end

            if (NA < W) begin : g_no_carry
                assign carry[c][W-1:NA] = '0;
            end

            assign reduced[c] = {{(W - NODES + FIRST){1'b0}}, node[NODES-1:FIRST]};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dots_out <= '0;
        end else begin
            dots_out <= reduced;
        end
    end

    // a dot above the column height is never read and would be lost
    assert property (@(posedge clk) disable iff (!nrst) (dots_in & ~IN_MASK) == '0)
        else $error("dadda_step %0d: dot above column height", STEP);

endmodule

`default_nettype wire

/* rtl/partial_product_gen.sv */
`default_nettype none

module partial_product_gen import dadda_pkg::*; (
    input  wire         clk,
    input  wire         nrst,
    input  wire         load,
    input  wire         operand_t a,
    input  wire         operand_t b,
    output dot_matrix_t dots
);

    localparam int W = $bits(operand_t);

    dot_matrix_t raw;

    // a[i] & b[j] lands in column i+j
    always_comb begin
        raw = '0;
        for (int i = 0; i < W; i++) begin
            for (int j = 0; j < W; j++) begin
                if (i + j < W) begin
                    raw[i + j][i] = a[i] & b[j];
                end else begin
                    // upper half, slot counted from the first i present
                    raw[i + j][W - 1 - j] = a[i] & b[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dots <= '0;
        end else if (load) begin
            dots <= raw;
        end
    end

endmodule

`default_nettype wire

/* rtl/dadda_ctrl.sv */
`default_nettype none

`include "dadda_params.svh"

module dadda_ctrl (
    input  wire  clk,
    input  wire  nrst,
    input  wire  start,
    output logic busy,
    output logic done,
    output logic load,
    output logic capture
);

    localparam int LAT = `DADDA_LATENCY;

    logic [LAT-1:0] token;
    logic           arm;

    assign load = start && !busy;

    // raw matrix is registered on the accept edge, token enters one edge later
    assign arm = busy && (token == '0);

    assign capture = token[1];
    assign done    = token[0];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            token <= '0;
            busy  <= 1'b0;
        end else begin
            token <= {arm, token[LAT-1:1]};
            if (load) begin
                busy <= 1'b1;
            end else if (capture) begin
                busy <= 1'b0;
            end
        end
    end

    // single operation in flight
    assert property (@(posedge clk) disable iff (!nrst) $onehot0(token))
        else $error("dadda_ctrl: token is not one-hot");

    assert property (@(posedge clk) disable iff (!nrst) !(done && busy))
        else $error("dadda_ctrl: done while busy");

endmodule

`default_nettype wire

/* rtl/dadda_pkg.sv */
`default_nettype none

`include "dadda_params.svh"

package dadda_pkg;

    typedef logic [`DADDA_WIDTH-1:0] operand_t;
    typedef logic [`DADDA_PROD_WIDTH-1:0] product_t;

    // dots[col][slot], valid dots always packed into the low slots
    typedef logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] dot_matrix_t;

    // dots per column of the raw and array
    function automatic int initial_height(int col);
        if (col < `DADDA_WIDTH) begin
            return col + 1;
        end
        return 2 * `DADDA_WIDTH - 1 - col;
    endfunction

    // dadda sequence 2 3 4 6 9 13, last step reaches 2
    function automatic int dadda_target(int k);
        int d;
        d = 2;
        for (int s = k + 1; s < `DADDA_STEPS; s++) begin
            d = d * 3 / 2;
        end
        return d;
    endfunction

    // column height once step k is done, k of -1 gives the raw array
    function automatic int height_after(int col, int k);
        int h [`DADDA_PROD_WIDTH];
        int cin;
        int exc;
        int t;
        for (int c = 0; c < `DADDA_PROD_WIDTH; c++) begin
            h[c] = initial_height(c);
        end
        for (int s = 0; s <= k; s++) begin
            t = dadda_target(s);
            cin = 0;
            for (int c = 0; c < `DADDA_PROD_WIDTH; c++) begin
                exc = h[c] + cin - t;
                if (exc > 0) begin
                    h[c] = t;
                    cin = (exc + 1) / 2;
                end else begin
                    h[c] = h[c] + cin;
                    cin = 0;
                end
            end
        end
        return h[col];
    endfunction

endpackage

`default_nettype wire

/* rtl/dadda_params.svh */
`ifndef DADDA_PARAMS_SVH
`define DADDA_PARAMS_SVH

// operand width of the multiplier
`define DADDA_WIDTH 24

// full unsigned product
`define DADDA_PROD_WIDTH (2 * `DADDA_WIDTH)

// reduction steps, column heights 13 9 6 4 3 2
`define DADDA_STEPS 6

// edges from an accepted start to a valid product
`define DADDA_LATENCY 8

`endif
